/* bus_params.svh */
`ifndef BUS_PARAMS_SVH
`define BUS_PARAMS_SVH

// high byte of the cpu i/o page, 0x9Fxx
`define BUS_IO_PAGE         8'h9F

// device nibbles, address bits 7..4 inside the i/o page
// vera takes two nibbles (2 and 3), decoded directly
`define BUS_DEV_VIA1        4'h0
`define BUS_DEV_AURA        4'h4
`define BUS_DEV_SCRB        4'h5
`define BUS_DEV_ENET        4'h8

// rom pages start at sram page 64, i.e. address bits 20..19 = 01
`define BUS_ROM_PAGE_BASE   2'b01
// ram window pages are placed from the middle of sram
`define BUS_RAMBANK_FLIP    8'h80
// rom bank after reset, bit 5 set selects the internal bootrom
`define BUS_ROMBANK_RESET   6'd63
// extra clk6x cycles added to s4 for the lan controller
`define BUS_ENET_EXT        2'd1

`endif

/* bus_pkg.sv */
`default_nettype none

package bus_pkg;

    // data byte, also used for the 65C816 bank byte
    typedef logic [7:0] byte_t;

    // rom bank number, bit 5 means bootrom
    typedef logic [5:0] rombank_t;

    // memory address bits 20..12
    typedef logic [8:0] mem_abh_t;

    // cpu address bits 15..12
    typedef logic [3:0] cpu_abh_t;

    // device hit inside the i/o page
    typedef enum logic [2:0] {
        io_none,
        io_via1,
        io_vera,
        io_aura,
        io_scrb,
        io_enet
    } io_dev_e;

endpackage

`default_nettype wire

/* io_page_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_params.svh"

module io_page_decode
    import bus_pkg::*;
(
    // low byte of the cpu address, only bits 7..4 matter
    input  byte_t   abl_lo_i,
    // which device is hit
    output io_dev_e dev_o
);

    logic [3:0] dev_nib;

    // 16-byte slots inside the 0x9Fxx page
    assign dev_nib = abl_lo_i[7:4];

    always_comb
    begin
        case (dev_nib)
            `BUS_DEV_VIA1:
                dev_o = io_via1;
            // vera covers 0x9F20..0x9F3F
            4'h2,
            4'h3:
                dev_o = io_vera;
            `BUS_DEV_AURA:
                dev_o = io_aura;
            `BUS_DEV_SCRB:
                dev_o = io_scrb;
            `BUS_DEV_ENET:
                dev_o = io_enet;
            // unmapped slots are silently ignored
            default:
                dev_o = io_none;
        endcase
    end

endmodule

`default_nettype wire

/* addr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_params.svh"

module addr_decode
    import bus_pkg::*;
(
    input  logic        clk6x,
    input  logic        resetn,
    // 1 = 65C02, 0 = 65C816
    input  logic        cputype02_i,
    input  cpu_abh_t    cpu_abh_i,
    input  logic [11:0] memcpu_abl_i,
    // carries the bank byte of a 65C816 at setup time
    input  byte_t       cpu_db_i,
    input  logic        cpu_rw_i,
    // vector pull, active low
    input  logic        cpu_vpu_i,
    input  logic        cpu_vda_i,
    input  logic        cpu_sync_vpa_i,
    // phaser strobes
    input  logic        setup_cs_i,
    input  logic        release_wr_i,
    input  logic        release_cs_i,
    // current banks
    input  rombank_t    rombank_i,
    input  byte_t       rambank_masked_i,
    // external chip selects, active low
    output logic        sram_csn_o,
    output logic        vera_csn_o,
    output logic        aio_csn_o,
    output logic        enet_csn_o,
    output logic        mem_rdn_o,
    output logic        mem_wrn_o,
    output mem_abh_t    mem_abh_o,
    output logic [11:0] memcpu_abl_o,
    // internal slave side
    output logic [15:0] nora_slv_addr_o,
    output logic        nora_slv_rwn_o,
    output logic        slv_req_bootrom_o,
    output logic        slv_req_scrb_o,
    output logic        slv_req_via1_o,
    output logic        bankreg_req_o,
    output logic [1:0]  s4_ext_o
);

    logic [15:0] cpu_ab;
    byte_t       cpu_bank;
    logic        bus_valid;
    io_dev_e     io_dev;

    // decoded values, loaded on setup_cs
    logic        dec_sram;
    logic        dec_vera;
    logic        dec_aio;
    logic        dec_enet;
    logic        dec_rom;
    logic        dec_bootrom;
    logic        dec_scrb;
    logic        dec_via1;
    logic        dec_bankreg;
    logic        dec_ext_acc;
    mem_abh_t    dec_abh;
    logic [1:0]  dec_s4_ext;

    assign cpu_ab = {cpu_abh_i, memcpu_abl_i};
    // 65C02 always runs in bank 0
    assign cpu_bank = cputype02_i ? 8'h00 : cpu_db_i;
    // 65C816 cycles without vda and vpa are internal operations
    assign bus_valid = cputype02_i || cpu_vda_i || cpu_sync_vpa_i;

    io_page_decode u_io_page_decode (
        .abl_lo_i (memcpu_abl_i[7:0]),
        .dev_o    (io_dev)
    );

    always_comb
    begin
        dec_sram    = 1'b0;
        dec_vera    = 1'b0;
        dec_aio     = 1'b0;
        dec_enet    = 1'b0;
        dec_rom     = 1'b0;
        dec_bootrom = 1'b0;
        dec_scrb    = 1'b0;
        dec_via1    = 1'b0;
        dec_bankreg = 1'b0;
        dec_s4_ext  = 2'd0;
        // memory address keeps its last value unless a region sets it
        dec_abh     = mem_abh_o;
        if (bus_valid && cpu_bank == 8'h00)
        begin
            if (cpu_ab[15:1] == 15'h0000)
            begin
                // 0x0000 rambank, 0x0001 rombank
                dec_bankreg = 1'b1;
            end
            else if (cpu_abh_i[3:2] == 2'b11)
            begin
                // 0xC000..0xFFFF rom window
                if (rombank_i[5])
                begin
                    dec_bootrom = 1'b1;
                    dec_abh     = '0;
                end
                else
                begin
                    dec_sram = 1'b1;
                    dec_rom  = 1'b1;
                    // vector pull always comes from rom bank 0
                    if (!cpu_vpu_i)
                        dec_abh = {`BUS_ROM_PAGE_BASE, 5'd0, cpu_abh_i[1:0]};
                    else
                        dec_abh = {`BUS_ROM_PAGE_BASE, rombank_i[4:0], cpu_abh_i[1:0]};
                end
            end
            else if (cpu_abh_i[3:1] == 3'b101)
            begin
                // 0xA000..0xBFFF 8k ram window
                dec_sram = 1'b1;
                dec_abh  = {rambank_masked_i ^ `BUS_RAMBANK_FLIP, cpu_abh_i[0]};
            end
            else if (cpu_ab[15:8] == `BUS_IO_PAGE)
            begin
                dec_via1 = (io_dev == io_via1);
                dec_vera = (io_dev == io_vera);
                dec_aio  = (io_dev == io_aura);
                dec_scrb = (io_dev == io_scrb);
                dec_enet = (io_dev == io_enet);
                // lan chip needs a longer s4 phase
                if (io_dev == io_enet)
                    dec_s4_ext = `BUS_ENET_EXT;
            end
            else
            begin
                // low cpu memory on sram pages 0..9
                dec_sram = 1'b1;
                dec_abh  = {5'h00, cpu_abh_i};
            end
        end
        else if (bus_valid)
        begin
            // 65C816 upper banks, linear sram
            dec_sram = 1'b1;
            dec_abh  = {cpu_bank[4:0], cpu_abh_i};
        end
    end

    assign dec_ext_acc = dec_sram || dec_vera || dec_aio || dec_enet;

    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            sram_csn_o        <= 1'b1;
            vera_csn_o        <= 1'b1;
            aio_csn_o         <= 1'b1;
            enet_csn_o        <= 1'b1;
            mem_rdn_o         <= 1'b1;
            mem_wrn_o         <= 1'b1;
            slv_req_bootrom_o <= 1'b0;
            slv_req_scrb_o    <= 1'b0;
            slv_req_via1_o    <= 1'b0;
            bankreg_req_o     <= 1'b0;
            s4_ext_o          <= 2'd0;
        end
        else
        begin
            if (setup_cs_i)
            begin
                sram_csn_o        <= !dec_sram;
                vera_csn_o        <= !dec_vera;
                aio_csn_o         <= !dec_aio;
                enet_csn_o        <= !dec_enet;
                mem_rdn_o         <= !(dec_ext_acc && cpu_rw_i);
                // rom pages are never written
                mem_wrn_o         <= !(dec_ext_acc && !cpu_rw_i && !dec_rom);
                slv_req_bootrom_o <= dec_bootrom;
                slv_req_scrb_o    <= dec_scrb;
                slv_req_via1_o    <= dec_via1;
                bankreg_req_o     <= dec_bankreg;
                s4_ext_o          <= dec_s4_ext;
            end
            // end write early so the write latch gets hold time before cs drops
            if (release_wr_i)
                mem_wrn_o <= 1'b1;
            // end of cycle, overrides a coincident setup
            if (release_cs_i)
            begin
                sram_csn_o        <= 1'b1;
                vera_csn_o        <= 1'b1;
                aio_csn_o         <= 1'b1;
                enet_csn_o        <= 1'b1;
                mem_rdn_o         <= 1'b1;
                mem_wrn_o         <= 1'b1;
                slv_req_bootrom_o <= 1'b0;
                slv_req_scrb_o    <= 1'b0;
                slv_req_via1_o    <= 1'b0;
                bankreg_req_o     <= 1'b0;
            end
        end
    end

    // address and direction of the current cycle
    always_ff @(posedge clk6x)
    begin
        if (setup_cs_i)
        begin
            memcpu_abl_o    <= memcpu_abl_i;
            nora_slv_addr_o <= cpu_ab;
            nora_slv_rwn_o  <= cpu_rw_i;
            mem_abh_o       <= dec_abh;
        end
    end

endmodule

`default_nettype wire

/* bank_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_params.svh"

module bank_regs
    import bus_pkg::*;
(
    input  logic     clk6x,
    input  logic     resetn,
    // cpu cycle targets 0x0000/0x0001
    input  logic     bankreg_req_i,
    // 0 = rambank, 1 = rombank
    input  logic     reg_sel_i,
    input  logic     slv_rwn_i,
    input  logic     release_wr_i,
    input  byte_t    wdata_i,
    // limits the usable ram banks
    input  byte_t    rambank_mask_i,
    output rombank_t rombank_o,
    output byte_t    rambank_masked_o,
    output byte_t    bank_rdata_o
);

    byte_t rambank_r;

    // cpu write data is only valid at the end of the cycle
    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            rambank_r <= 8'h00;
            // boot from the internal rom
            rombank_o <= `BUS_ROMBANK_RESET;
        end
        else if (release_wr_i && bankreg_req_i && !slv_rwn_i)
        begin
            if (!reg_sel_i)
                rambank_r <= wdata_i;
            else
                rombank_o <= wdata_i[5:0];
        end
    end

    // masked bank precomputed, keeps the and gate out of the decode path
    always_ff @(posedge clk6x)
    begin
        rambank_masked_o <= rambank_r & rambank_mask_i;
    end

    // readback, unmasked
    assign bank_rdata_o = reg_sel_i ? {2'b00, rombank_o} : rambank_r;

endmodule

`default_nettype wire

/* cpu_data_return.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_data_return
    import bus_pkg::*;
(
    input  logic  clk6x,
    // external read strobe, active low
    input  logic  mem_rdn_i,
    input  logic  bankreg_req_i,
    input  byte_t bank_rdata_i,
    input  logic  slv_req_bootrom_i,
    input  logic  slv_req_scrb_i,
    input  logic  slv_req_via1_i,
    // external memory and device data
    input  byte_t mem_db_i,
    // read data from the internal slaves
    input  byte_t slv_data_i,
    output byte_t cpu_db_o
);

    // byte held for the cpu until the next source is selected
    always_ff @(posedge clk6x)
    begin
        if (!mem_rdn_i)
            cpu_db_o <= mem_db_i;
        else if (bankreg_req_i)
            cpu_db_o <= bank_rdata_i;
        else if (slv_req_bootrom_i || slv_req_scrb_i || slv_req_via1_i)
            cpu_db_o <= slv_data_i;
    end

endmodule

`default_nettype wire

/* bus_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_controller
    import bus_pkg::*;
(
    input  logic        clk6x,
    input  logic        resetn,
    input  logic        cputype02_i,
    // cpu bus
    output byte_t       cpu_db_o,
    input  byte_t       cpu_db_i,
    input  cpu_abh_t    cpu_abh_i,
    input  logic        cpu_sync_vpa_i,
    input  logic        cpu_vpu_i,
    input  logic        cpu_vda_i,
    input  logic        cpu_rw_i,
    // memory bus
    output mem_abh_t    mem_abh_o,
    output logic [11:0] memcpu_abl_o,
    input  logic [11:0] memcpu_abl_i,
    input  byte_t       mem_db_i,
    output byte_t       mem_db_o,
    output logic        mem_rdn_o,
    output logic        mem_wrn_o,
    output logic        sram_csn_o,
    output logic        vera_csn_o,
    output logic        aio_csn_o,
    output logic        enet_csn_o,
    // phaser
    input  logic        setup_cs_i,
    input  logic        release_wr_i,
    input  logic        release_cs_i,
    output logic [1:0]  s4_ext_o,
    // internal slaves
    output logic [15:0] nora_slv_addr_o,
    output byte_t       nora_slv_datawr_o,
    output logic        nora_slv_datawr_valid_o,
    input  byte_t       nora_slv_data_i,
    output logic        nora_slv_req_bootrom_o,
    output logic        nora_slv_req_scrb_o,
    output logic        nora_slv_req_via1_o,
    output logic        nora_slv_rwn_o,
    // from scrb
    input  byte_t       rambank_mask_i
);

    rombank_t rombank;
    byte_t    rambank_masked;
    byte_t    bank_rdata;
    logic     bankreg_req;

    // write data is the cpu byte, valid at release_wr
    assign mem_db_o                = cpu_db_i;
    assign nora_slv_datawr_o       = cpu_db_i;
    assign nora_slv_datawr_valid_o = release_wr_i;

    addr_decode u_addr_decode (
        .clk6x             (clk6x),
        .resetn            (resetn),
        .cputype02_i       (cputype02_i),
        .cpu_abh_i         (cpu_abh_i),
        .memcpu_abl_i      (memcpu_abl_i),
        .cpu_db_i          (cpu_db_i),
        .cpu_rw_i          (cpu_rw_i),
        .cpu_vpu_i         (cpu_vpu_i),
        .cpu_vda_i         (cpu_vda_i),
        .cpu_sync_vpa_i    (cpu_sync_vpa_i),
        .setup_cs_i        (setup_cs_i),
        .release_wr_i      (release_wr_i),
        .release_cs_i      (release_cs_i),
        .rombank_i         (rombank),
        .rambank_masked_i  (rambank_masked),
        .sram_csn_o        (sram_csn_o),
        .vera_csn_o        (vera_csn_o),
        .aio_csn_o         (aio_csn_o),
        .enet_csn_o        (enet_csn_o),
        .mem_rdn_o         (mem_rdn_o),
        .mem_wrn_o         (mem_wrn_o),
        .mem_abh_o         (mem_abh_o),
        .memcpu_abl_o      (memcpu_abl_o),
        .nora_slv_addr_o   (nora_slv_addr_o),
        .nora_slv_rwn_o    (nora_slv_rwn_o),
        .slv_req_bootrom_o (nora_slv_req_bootrom_o),
        .slv_req_scrb_o    (nora_slv_req_scrb_o),
        .slv_req_via1_o    (nora_slv_req_via1_o),
        .bankreg_req_o     (bankreg_req),
        .s4_ext_o          (s4_ext_o)
    );

    // register select is cpu address bit 0
    bank_regs u_bank_regs (
        .clk6x            (clk6x),
        .resetn           (resetn),
        .bankreg_req_i    (bankreg_req),
        .reg_sel_i        (nora_slv_addr_o[0]),
        .slv_rwn_i        (nora_slv_rwn_o),
        .release_wr_i     (release_wr_i),
        .wdata_i          (cpu_db_i),
        .rambank_mask_i   (rambank_mask_i),
        .rombank_o        (rombank),
        .rambank_masked_o (rambank_masked),
        .bank_rdata_o     (bank_rdata)
    );

    cpu_data_return u_cpu_data_return (
        .clk6x             (clk6x),
        .mem_rdn_i         (mem_rdn_o),
        .bankreg_req_i     (bankreg_req),
        .bank_rdata_i      (bank_rdata),
        .slv_req_bootrom_i (nora_slv_req_bootrom_o),
        .slv_req_scrb_i    (nora_slv_req_scrb_o),
        .slv_req_via1_i    (nora_slv_req_via1_o),
        .mem_db_i          (mem_db_i),
        .slv_data_i        (nora_slv_data_i),
        .cpu_db_o          (cpu_db_o)
    );

endmodule

`default_nettype wire

/* tb_bus_controller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_params.svh"

module tb_bus_controller
    import bus_pkg::*;
();

    localparam int RESET_CYCLES  = 16;
    localparam int TBL_MAX       = 32;
    // drive, setup, check, wr on, wr off, cs on, cs off
    localparam int CYC_PER_ENTRY = 7;
    localparam int CYCLE_LIMIT   = RESET_CYCLES + TBL_MAX * CYC_PER_ENTRY + 8;

    // one cpu cycle of stimulus with its expected response
    // sel is {sram_csn, vera_csn, aio_csn, enet_csn, mem_rdn, mem_wrn}
    // req is {bootrom, scrb, via1}
    typedef struct packed {
        logic        cpu02;
        byte_t       bank;
        logic [15:0] addr;
        logic        rw;
        logic        vpu;
        logic        vda;
        logic        vpa;
        byte_t       wdata;
        byte_t       mask;
        byte_t       rdata;
        logic [5:0]  sel;
        logic [2:0]  req;
        logic [1:0]  ext;
        logic        chk_abh;
        mem_abh_t    abh;
        logic        chk_db;
        byte_t       db;
    } entry_t;

    logic        clk6x;
    logic        resetn;
    logic        cputype02_i;
    byte_t       cpu_db_i;
    cpu_abh_t    cpu_abh_i;
    logic        cpu_sync_vpa_i;
    logic        cpu_vpu_i;
    logic        cpu_vda_i;
    logic        cpu_rw_i;
    logic [11:0] memcpu_abl_i;
    byte_t       mem_db_i;
    logic        setup_cs_i;
    logic        release_wr_i;
    logic        release_cs_i;
    byte_t       nora_slv_data_i;
    byte_t       rambank_mask_i;

    byte_t       cpu_db_o;
    mem_abh_t    mem_abh_o;
    logic [11:0] memcpu_abl_o;
    byte_t       mem_db_o;
    logic        mem_rdn_o;
    logic        mem_wrn_o;
    logic        sram_csn_o;
    logic        vera_csn_o;
    logic        aio_csn_o;
    logic        enet_csn_o;
    logic [1:0]  s4_ext_o;
    logic [15:0] nora_slv_addr_o;
    byte_t       nora_slv_datawr_o;
    logic        nora_slv_datawr_valid_o;
    logic        nora_slv_req_bootrom_o;
    logic        nora_slv_req_scrb_o;
    logic        nora_slv_req_via1_o;
    logic        nora_slv_rwn_o;

    entry_t tbl [0:TBL_MAX-1];
    string  tname [0:TBL_MAX-1];
    int     n_tbl;
    string  cur_name;
    int     errors;
    int     checks;
    int     tests_failed;
    int     cycles;

    bus_controller DUT (
        .clk6x                   (clk6x),
        .resetn                  (resetn),
        .cputype02_i             (cputype02_i),
        .cpu_db_o                (cpu_db_o),
        .cpu_db_i                (cpu_db_i),
        .cpu_abh_i               (cpu_abh_i),
        .cpu_sync_vpa_i          (cpu_sync_vpa_i),
        .cpu_vpu_i               (cpu_vpu_i),
        .cpu_vda_i               (cpu_vda_i),
        .cpu_rw_i                (cpu_rw_i),
        .mem_abh_o               (mem_abh_o),
        .memcpu_abl_o            (memcpu_abl_o),
        .memcpu_abl_i            (memcpu_abl_i),
        .mem_db_i                (mem_db_i),
        .mem_db_o                (mem_db_o),
        .mem_rdn_o               (mem_rdn_o),
        .mem_wrn_o               (mem_wrn_o),
        .sram_csn_o              (sram_csn_o),
        .vera_csn_o              (vera_csn_o),
        .aio_csn_o               (aio_csn_o),
        .enet_csn_o              (enet_csn_o),
        .setup_cs_i              (setup_cs_i),
        .release_wr_i            (release_wr_i),
        .release_cs_i            (release_cs_i),
        .s4_ext_o                (s4_ext_o),
        .nora_slv_addr_o         (nora_slv_addr_o),
        .nora_slv_datawr_o       (nora_slv_datawr_o),
        .nora_slv_datawr_valid_o (nora_slv_datawr_valid_o),
        .nora_slv_data_i         (nora_slv_data_i),
        .nora_slv_req_bootrom_o  (nora_slv_req_bootrom_o),
        .nora_slv_req_scrb_o     (nora_slv_req_scrb_o),
        .nora_slv_req_via1_o     (nora_slv_req_via1_o),
        .nora_slv_rwn_o          (nora_slv_rwn_o),
        .rambank_mask_i          (rambank_mask_i)
    );

    // 4 ns clock
    initial
    begin
        clk6x = 1'b0;
        forever #2 clk6x = ~clk6x;
    end

    // run limit scaled to the largest table
    always @(posedge clk6x)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout after %0d cycles, the test sequence did not finish", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_level(input string sig, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            $display("FAIL %s %s: got %h expected %h", cur_name, sig, got, exp);
            errors++;
        end
    endtask

    task automatic check_ext(input string sig, input logic [1:0] got, input logic [1:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("FAIL %s %s: got %h expected %h", cur_name, sig, got, exp);
            errors++;
        end
    endtask

    task automatic check_byte(input string sig, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp)
        begin
            $display("FAIL %s %s: got %h expected %h", cur_name, sig, got, exp);
            errors++;
        end
    endtask

    task automatic check_abh(input string sig, input mem_abh_t got, input mem_abh_t exp);
        checks++;
        if (got !== exp)
        begin
            $display("FAIL %s %s: got %h expected %h", cur_name, sig, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string sig, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("FAIL %s %s: got %h expected %h", cur_name, sig, got, exp);
            errors++;
        end
    endtask

    task automatic check_abl(input string sig, input logic [11:0] got, input logic [11:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("FAIL %s %s: got %h expected %h", cur_name, sig, got, exp);
            errors++;
        end
    endtask

    // every select, strobe and request released
    task automatic check_idle();
        check_level("sram_csn_o", sram_csn_o, 1'b1);
        check_level("vera_csn_o", vera_csn_o, 1'b1);
        check_level("aio_csn_o", aio_csn_o, 1'b1);
        check_level("enet_csn_o", enet_csn_o, 1'b1);
        check_level("mem_rdn_o", mem_rdn_o, 1'b1);
        check_level("mem_wrn_o", mem_wrn_o, 1'b1);
        check_level("nora_slv_req_bootrom_o", nora_slv_req_bootrom_o, 1'b0);
        check_level("nora_slv_req_scrb_o", nora_slv_req_scrb_o, 1'b0);
        check_level("nora_slv_req_via1_o", nora_slv_req_via1_o, 1'b0);
        check_level("bankreg_req", DUT.bankreg_req, 1'b0);
    endtask

    task automatic add_cycle(
        input string       name,
        input logic        cpu02,
        input byte_t       bank,
        input logic [15:0] addr,
        input logic        rw,
        input logic        vpu,
        input logic        vda,
        input logic        vpa,
        input byte_t       wdata,
        input byte_t       mask,
        input byte_t       rdata,
        input logic [5:0]  sel,
        input logic [2:0]  req,
        input logic [1:0]  ext,
        input logic        chk_abh,
        input mem_abh_t    abh,
        input logic        chk_db,
        input byte_t       db
    );
        tbl[n_tbl] = '{cpu02, bank, addr, rw, vpu, vda, vpa, wdata, mask, rdata,
                       sel, req, ext, chk_abh, abh, chk_db, db};
        tname[n_tbl] = name;
        n_tbl++;
    endtask

    task automatic apply_cycle(input int idx);
        entry_t e;
        int     errs_before;
        e = tbl[idx];
        errs_before = errors;
        cur_name = tname[idx];
        // address and mask first so the masked bank is settled at setup
        @(posedge clk6x);
        cputype02_i     <= e.cpu02;
        cpu_db_i        <= e.bank;
        cpu_abh_i       <= e.addr[15:12];
        memcpu_abl_i    <= e.addr[11:0];
        cpu_rw_i        <= e.rw;
        cpu_vpu_i       <= e.vpu;
        cpu_vda_i       <= e.vda;
        cpu_sync_vpa_i  <= e.vpa;
        rambank_mask_i  <= e.mask;
        mem_db_i        <= e.rdata;
        // slave data differs from memory data so the source is visible
        nora_slv_data_i <= ~e.rdata;
        @(posedge clk6x);
        setup_cs_i <= 1'b1;
        @(posedge clk6x);
        setup_cs_i <= 1'b0;
        // the bus carries write data once the bank byte is decoded
        cpu_db_i   <= e.wdata;
        @(negedge clk6x);
        check_level("sram_csn_o", sram_csn_o, e.sel[5]);
        check_level("vera_csn_o", vera_csn_o, e.sel[4]);
        check_level("aio_csn_o", aio_csn_o, e.sel[3]);
        check_level("enet_csn_o", enet_csn_o, e.sel[2]);
        check_level("mem_rdn_o", mem_rdn_o, e.sel[1]);
        check_level("mem_wrn_o", mem_wrn_o, e.sel[0]);
        check_level("nora_slv_req_bootrom_o", nora_slv_req_bootrom_o, e.req[2]);
        check_level("nora_slv_req_scrb_o", nora_slv_req_scrb_o, e.req[1]);
        check_level("nora_slv_req_via1_o", nora_slv_req_via1_o, e.req[0]);
        check_ext("s4_ext_o", s4_ext_o, e.ext);
        // cycle address and direction as latched at setup
        check_addr("nora_slv_addr_o", nora_slv_addr_o, e.addr);
        check_abl("memcpu_abl_o", memcpu_abl_o, e.addr[11:0]);
        check_level("nora_slv_rwn_o", nora_slv_rwn_o, e.rw);
        if (e.chk_abh)
            check_abh("mem_abh_o", mem_abh_o, e.abh);
        @(posedge clk6x);
        release_wr_i <= 1'b1;
        @(negedge clk6x);
        check_level("nora_slv_datawr_valid_o", nora_slv_datawr_valid_o, 1'b1);
        if (!e.rw)
        begin
            check_byte("mem_db_o", mem_db_o, e.wdata);
            check_byte("nora_slv_datawr_o", nora_slv_datawr_o, e.wdata);
        end
        @(posedge clk6x);
        release_wr_i <= 1'b0;
        @(negedge clk6x);
        check_level("mem_wrn_o", mem_wrn_o, 1'b1);
        check_level("nora_slv_datawr_valid_o", nora_slv_datawr_valid_o, 1'b0);
        // read byte was captured while the cycle was still selected
        if (e.chk_db)
            check_byte("cpu_db_o", cpu_db_o, e.db);
        @(posedge clk6x);
        release_cs_i <= 1'b1;
        @(posedge clk6x);
        release_cs_i <= 1'b0;
        @(negedge clk6x);
        check_idle();
        if (errors == errs_before)
            $display("test %0d %s: ok", idx + 1, cur_name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: FAILED", idx + 1, cur_name);
        end
    endtask

    initial
    begin
        int          k;
        logic [31:0] rng;
        logic [15:0] win_addr;
        mem_abh_t    win_abh;
        cycles          = 0;
        errors          = 0;
        checks          = 0;
        tests_failed    = 0;
        n_tbl           = 0;
        resetn          = 1'b0;
        cputype02_i     = 1'b1;
        cpu_db_i        = 8'h00;
        cpu_abh_i       = 4'h0;
        cpu_sync_vpa_i  = 1'b0;
        cpu_vpu_i       = 1'b1;
        cpu_vda_i       = 1'b0;
        cpu_rw_i        = 1'b1;
        memcpu_abl_i    = 12'h000;
        mem_db_i        = 8'h00;
        setup_cs_i      = 1'b0;
        release_wr_i    = 1'b0;
        release_cs_i    = 1'b0;
        nora_slv_data_i = 8'h00;
        rambank_mask_i  = 8'hFF;

        // 65C02 low memory and rom window with rom bank 63 from reset
        add_cycle("c02 low read", 1'b1, 8'h00, 16'h1234, 1'b1, 1'b1, 1'b1, 1'b1, 8'h00,
                  8'hFF, 8'h5A, 6'b011101, 3'b000, 2'd0, 1'b1, 9'h001, 1'b1, 8'h5A);
        add_cycle("c02 9exx read", 1'b1, 8'h00, 16'h9E80, 1'b1, 1'b1, 1'b1, 1'b1, 8'h00,
                  8'hFF, 8'hC3, 6'b011101, 3'b000, 2'd0, 1'b1, 9'h009, 1'b1, 8'hC3);
        add_cycle("bootrom read", 1'b1, 8'h00, 16'hC000, 1'b1, 1'b1, 1'b1, 1'b1, 8'h00,
                  8'hFF, 8'h11, 6'b111111, 3'b100, 2'd0, 1'b0, 9'h000, 1'b1, 8'hEE);
        // ram bank is zero after reset
        add_cycle("rambank reset read", 1'b1, 8'h00, 16'h0000, 1'b1, 1'b1, 1'b1, 1'b1, 8'h00,
                  8'hFF, 8'h6B, 6'b111111, 3'b000, 2'd0, 1'b0, 9'h000, 1'b1, 8'h00);
        add_cycle("rombank write", 1'b1, 8'h00, 16'h0001, 1'b0, 1'b1, 1'b1, 1'b1, 8'h05,
                  8'hFF, 8'h00, 6'b111111, 3'b000, 2'd0, 1'b0, 9'h000, 1'b0, 8'h00);
        add_cycle("rom bank 5 read", 1'b1, 8'h00, 16'hE123, 1'b1, 1'b1, 1'b1, 1'b1, 8'h00,
                  8'hFF, 8'h77, 6'b011101, 3'b000, 2'd0, 1'b1, 9'h096, 1'b1, 8'h77);
        add_cycle("rom write blocked", 1'b1, 8'h00, 16'hD000, 1'b0, 1'b1, 1'b1, 1'b1, 8'h66,
                  8'hFF, 8'h00, 6'b011111, 3'b000, 2'd0, 1'b1, 9'h095, 1'b0, 8'h00);
        add_cycle("vector pull", 1'b1, 8'h00, 16'hFFFC, 1'b1, 1'b0, 1'b1, 1'b1, 8'h00,
                  8'hFF, 8'h3C, 6'b011101, 3'b000, 2'd0, 1'b1, 9'h083, 1'b1, 8'h3C);
        // bank registers and the 8k ram window
        add_cycle("rambank write", 1'b1, 8'h00, 16'h0000, 1'b0, 1'b1, 1'b1, 1'b1, 8'h2B,
                  8'hFF, 8'h00, 6'b111111, 3'b000, 2'd0, 1'b0, 9'h000, 1'b0, 8'h00);
        add_cycle("rambank read", 1'b1, 8'h00, 16'h0000, 1'b1, 1'b1, 1'b1, 1'b1, 8'h00,
                  8'hFF, 8'h00, 6'b111111, 3'b000, 2'd0, 1'b0, 9'h000, 1'b1, 8'h2B);
        add_cycle("rombank read", 1'b1, 8'h00, 16'h0001, 1'b1, 1'b1, 1'b1, 1'b1, 8'h00,
                  8'hFF, 8'h00, 6'b111111, 3'b000, 2'd0, 1'b0, 9'h000, 1'b1, 8'h05);
        add_cycle("ram window read", 1'b1, 8'h00, 16'hA000, 1'b1, 1'b1, 1'b1, 1'b1, 8'h00,
                  8'hFF, 8'h99, 6'b011101, 3'b000, 2'd0, 1'b1, 9'h156, 1'b1, 8'h99);
        add_cycle("ram window masked", 1'b1, 8'h00, 16'hB800, 1'b0, 1'b1, 1'b1, 1'b1, 8'h44,
                  8'h0F, 8'h00, 6'b011110, 3'b000, 2'd0, 1'b1, 9'h117, 1'b0, 8'h00);
        // i/o page devices
        add_cycle("vera read", 1'b1, 8'h00, {`BUS_IO_PAGE, 8'h3A}, 1'b1, 1'b1, 1'b1, 1'b1,
                  8'h00, 8'hFF, 8'h42, 6'b101101, 3'b000, 2'd0, 1'b0, 9'h000, 1'b1, 8'h42);
        add_cycle("aura write", 1'b1, 8'h00, {`BUS_IO_PAGE, `BUS_DEV_AURA, 4'h0}, 1'b0, 1'b1,
                  1'b1, 1'b1, 8'h10, 8'hFF, 8'h00, 6'b110110, 3'b000, 2'd0, 1'b0, 9'h000,
                  1'b0, 8'h00);
        add_cycle("enet read", 1'b1, 8'h00, {`BUS_IO_PAGE, `BUS_DEV_ENET, 4'h1}, 1'b1, 1'b1,
                  1'b1, 1'b1, 8'h00, 8'hFF, 8'h81, 6'b111001, 3'b000, `BUS_ENET_EXT, 1'b0,
                  9'h000, 1'b1, 8'h81);
        add_cycle("via1 read", 1'b1, 8'h00, {`BUS_IO_PAGE, `BUS_DEV_VIA1, 4'h0}, 1'b1, 1'b1,
                  1'b1, 1'b1, 8'h00, 8'hFF, 8'h0F, 6'b111111, 3'b001, 2'd0, 1'b0, 9'h000,
                  1'b1, 8'hF0);
        add_cycle("scrb read", 1'b1, 8'h00, {`BUS_IO_PAGE, `BUS_DEV_SCRB, 4'h3}, 1'b1, 1'b1,
                  1'b1, 1'b1, 8'h00, 8'hFF, 8'hA5, 6'b111111, 3'b010, 2'd0, 1'b0, 9'h000,
                  1'b1, 8'h5A);
        // 65C816 cycles
        add_cycle("816 linear read", 1'b0, 8'h23, 16'h4567, 1'b1, 1'b1, 1'b1, 1'b0, 8'h00,
                  8'hFF, 8'h6E, 6'b011101, 3'b000, 2'd0, 1'b1, 9'h034, 1'b1, 8'h6E);
        add_cycle("816 internal op", 1'b0, 8'h00, 16'h2000, 1'b1, 1'b1, 1'b0, 1'b0, 8'h00,
                  8'hFF, 8'h00, 6'b111111, 3'b000, 2'd0, 1'b0, 9'h000, 1'b0, 8'h00);
        add_cycle("816 bank0 write", 1'b0, 8'h00, 16'h3210, 1'b0, 1'b1, 1'b0, 1'b1, 8'h12,
                  8'hFF, 8'h00, 6'b011110, 3'b000, 2'd0, 1'b1, 9'h003, 1'b0, 8'h00);

        // random bank values and masks through the ram window
        rng = 32'h799049d7;
        for (k = 0; k < 3; k++)
        begin
            rng = xorshift32(rng);
            win_addr = {3'b101, rng[16], 12'h345};
            win_abh  = {(rng[7:0] & rng[15:8]) ^ `BUS_RAMBANK_FLIP, rng[16]};
            add_cycle("rnd rambank write", 1'b1, 8'h00, 16'h0000, 1'b0, 1'b1, 1'b1, 1'b1,
                      rng[7:0], rng[15:8], 8'h00, 6'b111111, 3'b000, 2'd0, 1'b0, 9'h000,
                      1'b0, 8'h00);
            add_cycle("rnd rambank read", 1'b1, 8'h00, 16'h0000, 1'b1, 1'b1, 1'b1, 1'b1,
                      8'h00, rng[15:8], 8'h00, 6'b111111, 3'b000, 2'd0, 1'b0, 9'h000,
                      1'b1, rng[7:0]);
            add_cycle("rnd window read", 1'b1, 8'h00, win_addr, 1'b1, 1'b1, 1'b1, 1'b1,
                      8'h00, rng[15:8], rng[31:24], 6'b011101, 3'b000, 2'd0, 1'b1, win_abh,
                      1'b1, rng[31:24]);
        end

        repeat (RESET_CYCLES) @(posedge clk6x);
        resetn <= 1'b1;
        @(negedge clk6x);
        cur_name = "reset idle";
        check_idle();
        check_ext("s4_ext_o", s4_ext_o, 2'd0);
        if (errors == 0)
            $display("test 0 reset idle: ok");
        else
        begin
            tests_failed++;
            $display("test 0 reset idle: FAILED");
        end

        for (k = 0; k < n_tbl; k++)
            apply_cycle(k);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 n_tbl + 1, tests_failed, checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
bus_pkg.sv
io_page_decode.sv
addr_decode.sv
bank_regs.sv
cpu_data_return.sv
bus_controller.sv
tb_bus_controller.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_bus_controller
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) bus_params.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx '=== PASS ===' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
